/* verilog/bp_config_pkg.sv */
package bp_config_pkg;

    //////////////////////////////
    // branch target buffer geometry
    //////////////////////////////

    // set index from pc[5:2], tag from pc[31:6]
    localparam int btb_sets       = 16;
    localparam int btb_index_bits = 4;
    localparam int btb_tag_bits   = 26;

    //////////////////////////////
    // direction counter geometry
    //////////////////////////////

    // counter index from pc[7:2]
    localparam int counter_entries    = 64;
    localparam int counter_index_bits = 6;

    // every counter starts one step below taken
    localparam logic [1:0] counter_weakly_not_taken = 2'b01;

    // one way of one set, 59 bits
    typedef struct packed {
        logic                    valid;
        logic [btb_tag_bits-1:0] tag;
        logic [31:0]             target;
    } btb_entry;

endpackage

/* verilog/bp_branch_pkg.sv */
package bp_branch_pkg;

    // control transfer class of one instruction
    typedef enum logic [1:0] {
        kind_none   = 2'd0,
        kind_branch = 2'd1,
        kind_jal    = 2'd2,
        kind_jalr   = 2'd3
    } branch_kind;

    // major opcodes of the control transfer instructions
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } rv_opcode;

    // fetch stage request, 65 bits
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_request;

    // resolved control instruction from execute, 68 bits
    typedef struct packed {
        logic        valid;
        branch_kind  kind;
        logic [31:0] pc;
        logic [31:0] target;
        logic        taken;
    } resolve_update;

    // registered prediction back to fetch, 36 bits
    typedef struct packed {
        logic        valid;
        branch_kind  kind;
        logic        taken;
        logic [31:0] next_pc;
    } prediction;

endpackage

/* verilog/branch_predecode.sv */
module branch_predecode (
    input  logic [31:0]              instr,
    input  logic [31:0]              pc,
    output bp_branch_pkg::branch_kind kind,
    output logic [31:0]              static_target
);

    bp_branch_pkg::rv_opcode opcode;
    logic [31:0] b_imm;
    logic [31:0] j_imm;
    logic [31:0] sequential_pc;

    assign opcode = bp_branch_pkg::rv_opcode'(instr[6:0]);

    // B-type offset, bit 0 always zero
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};

    // J-type offset
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    assign sequential_pc = pc + 32'd4;

    //////////////////////////////
    // opcode to kind
    //////////////////////////////

    always_comb begin
        case (opcode)
            bp_branch_pkg::op_branch: begin
                kind = bp_branch_pkg::kind_branch;
            end
            bp_branch_pkg::op_jal: begin
                kind = bp_branch_pkg::kind_jal;
            end
            bp_branch_pkg::op_jalr: begin
                kind = bp_branch_pkg::kind_jalr;
            end
            default: begin
                kind = bp_branch_pkg::kind_none;
            end
        endcase
    end

    // jalr target depends on a register, so fall through
    always_comb begin
        case (kind)
            bp_branch_pkg::kind_branch: static_target = pc + b_imm;
            bp_branch_pkg::kind_jal:    static_target = pc + j_imm;
            default:                    static_target = sequential_pc;
        endcase
    end

endmodule

/* verilog/btb.sv */
module btb (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] lookup_pc,
    input  logic        write_valid,
    input  logic [31:0] write_pc,
    input  logic [31:0] write_target,
    output logic        hit,
    output logic [31:0] target
);

    bp_config_pkg::btb_entry ways [2][bp_config_pkg::btb_sets];
    // way to refill next when both ways are valid
    logic [bp_config_pkg::btb_sets-1:0] replace_bit;

    logic [bp_config_pkg::btb_index_bits-1:0] lookup_index;
    logic [bp_config_pkg::btb_tag_bits-1:0]   lookup_tag;
    logic [1:0]                               lookup_match;

    logic [bp_config_pkg::btb_index_bits-1:0] write_index;
    logic [bp_config_pkg::btb_tag_bits-1:0]   write_tag;
    logic [1:0]                               write_tag_match;
    logic [1:0]                               write_same;
    logic                                     write_skip;
    logic                                     write_way;

    //////////////////////////////
    // lookup
    //////////////////////////////

    assign lookup_index = lookup_pc[bp_config_pkg::btb_index_bits+1:2];
    assign lookup_tag   = lookup_pc[31:bp_config_pkg::btb_index_bits+2];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            lookup_match[w] = ways[w][lookup_index].valid &&
                              (ways[w][lookup_index].tag == lookup_tag);
        end
    end

    assign hit = |lookup_match;

    // way 0 has priority
    always_comb begin
        if (lookup_match[0]) begin
            target = ways[0][lookup_index].target;
        end else if (lookup_match[1]) begin
            target = ways[1][lookup_index].target;
        end else begin
            target = '0;
        end
    end

    //////////////////////////////
    // write way choice
    //////////////////////////////

    assign write_index = write_pc[bp_config_pkg::btb_index_bits+1:2];
    assign write_tag   = write_pc[31:bp_config_pkg::btb_index_bits+2];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            write_tag_match[w] = ways[w][write_index].valid &&
                                 (ways[w][write_index].tag == write_tag);
            write_same[w]      = write_tag_match[w] &&
                                 (ways[w][write_index].target == write_target);
        end
        // entry already up to date
        write_skip = |write_same;

        if (write_tag_match[0]) begin
            write_way = 1'b0;
        end else if (write_tag_match[1]) begin
            write_way = 1'b1;
        end else if (!ways[0][write_index].valid) begin
            write_way = 1'b0;
        end else if (!ways[1][write_index].valid) begin
            write_way = 1'b1;
        end else begin
            write_way = replace_bit[write_index];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < bp_config_pkg::btb_sets; s++) begin
                    ways[w][s].valid <= 1'b0;
                end
            end
            replace_bit <= '0;
        end else if (write_valid && !write_skip) begin
            ways[write_way][write_index].valid  <= 1'b1;
            ways[write_way][write_index].tag    <= write_tag;
            ways[write_way][write_index].target <= write_target;
            replace_bit[write_index]            <= ~write_way;
        end
    end

endmodule

/* verilog/direction_table.sv */
module direction_table (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] lookup_pc,
    input  logic        train_valid,
    input  logic [31:0] train_pc,
    input  logic        train_taken,
    output logic        taken_hint
);

    logic [1:0] counters [bp_config_pkg::counter_entries];

    logic [bp_config_pkg::counter_index_bits-1:0] lookup_index;
    logic [bp_config_pkg::counter_index_bits-1:0] train_index;
    logic [1:0]                                   train_count;

    assign lookup_index = lookup_pc[bp_config_pkg::counter_index_bits+1:2];
    assign train_index  = train_pc[bp_config_pkg::counter_index_bits+1:2];

    // upper bit set means taken
    assign taken_hint  = counters[lookup_index][1];
    assign train_count = counters[train_index];

    //////////////////////////////
    // saturating training
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < bp_config_pkg::counter_entries; i++) begin
                counters[i] <= bp_config_pkg::counter_weakly_not_taken;
            end
        end else if (train_valid) begin
            if (train_taken) begin
                if (train_count != 2'b11) begin
                    counters[train_index] <= train_count + 2'd1;
                end
            end else begin
                if (train_count != 2'b00) begin
                    counters[train_index] <= train_count - 2'd1;
                end
            end
        end
    end

endmodule

/* verilog/prediction_select.sv */
module prediction_select (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      fetch_valid,
    input  logic [31:0]               fetch_pc,
    input  bp_branch_pkg::branch_kind kind,
    input  logic [31:0]               static_target,
    input  logic                      hit,
    input  logic [31:0]               target,
    input  logic                      taken_hint,
    output bp_branch_pkg::prediction  predict
);

    logic [31:0] sequential_pc;
    logic        taken_next;
    logic [31:0] next_pc_next;

    logic                      valid_q;
    bp_branch_pkg::branch_kind kind_q;
    logic                      taken_q;
    logic [31:0]               next_pc_q;

    assign sequential_pc = fetch_pc + 32'd4;

    // buffer target wins over static target when taken
    always_comb begin
        case (kind)
            bp_branch_pkg::kind_jal: begin
                taken_next = 1'b1;
            end
            bp_branch_pkg::kind_branch: begin
                taken_next = taken_hint;
            end
            bp_branch_pkg::kind_jalr: begin
                // no static target, so a miss falls through
                taken_next = hit;
            end
            default: begin
                taken_next = 1'b0;
            end
        endcase

        if (!taken_next) begin
            next_pc_next = sequential_pc;
        end else if (hit) begin
            next_pc_next = target;
        end else begin
            next_pc_next = static_target;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_valid;
        end
    end

    always_ff @(posedge clock) begin
        kind_q    <= kind;
        taken_q   <= taken_next;
        next_pc_q <= next_pc_next;
    end

    always_comb begin
        predict.valid   = valid_q;
        predict.kind    = kind_q;
        predict.taken   = taken_q;
        predict.next_pc = next_pc_q;
    end

endmodule

/* verilog/branch_predictor.sv */
module branch_predictor (
    input  logic                         clock,
    input  logic                         reset,
    input  bp_branch_pkg::fetch_request  fetch,
    input  bp_branch_pkg::resolve_update update,
    output bp_branch_pkg::prediction     predict
);

    bp_branch_pkg::branch_kind kind;
    logic [31:0]               static_target;
    logic                      btb_hit;
    logic [31:0]               btb_target;
    logic                      taken_hint;

    logic btb_write;
    logic counter_train;

    //////////////////////////////
    // update strobes
    //////////////////////////////

    // only taken control transfers carry a target worth storing
    assign btb_write = update.valid && update.taken &&
                       (update.kind != bp_branch_pkg::kind_none);
    assign counter_train = update.valid && (update.kind == bp_branch_pkg::kind_branch);

    //////////////////////////////
    // blocks
    //////////////////////////////

    branch_predecode u_predecode (
        .instr         (fetch.instr),
        .pc            (fetch.pc),
        .kind          (kind),
        .static_target (static_target)
    );

    btb u_btb (
        .clock        (clock),
        .reset        (reset),
        .lookup_pc    (fetch.pc),
        .write_valid  (btb_write),
        .write_pc     (update.pc),
        .write_target (update.target),
        .hit          (btb_hit),
        .target       (btb_target)
    );

    direction_table u_direction_table (
        .clock       (clock),
        .reset       (reset),
        .lookup_pc   (fetch.pc),
        .train_valid (counter_train),
        .train_pc    (update.pc),
        .train_taken (update.taken),
        .taken_hint  (taken_hint)
    );

    prediction_select u_select (
        .clock         (clock),
        .reset         (reset),
        .fetch_valid   (fetch.valid),
        .fetch_pc      (fetch.pc),
        .kind          (kind),
        .static_target (static_target),
        .hit           (btb_hit),
        .target        (btb_target),
        .taken_hint    (taken_hint),
        .predict       (predict)
    );

endmodule

/* verification/branch_predictor_tb.sv */
module branch_predictor_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    clock_period   = 10;
    localparam int    reset_cycles   = 16;
    localparam int    watchdog_slack = 20;
    localparam int    field_count    = 12;
    localparam string test_file      = "verification/bp_tests.txt";

    logic                         clock;
    logic                         reset;
    bp_branch_pkg::fetch_request  fetch;
    bp_branch_pkg::resolve_update update;
    bp_branch_pkg::prediction     predict;

    // one entry per data line
    bp_branch_pkg::fetch_request  fetch_q[$];
    bp_branch_pkg::resolve_update update_q[$];
    bp_branch_pkg::prediction     expected_q[$];
    logic                         tests_loaded;

    branch_predictor DUT (
        .clock   (clock),
        .reset   (reset),
        .fetch   (fetch),
        .update  (update),
        .predict (predict)
    );

    initial clock = 1'b0;
    always #(clock_period / 2) clock = ~clock;

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_prediction(input int test_no, input bp_branch_pkg::prediction got,
                                    input bp_branch_pkg::prediction want);
        if (got !== want) begin
            $display("Error at time %0t: test %0d prediction valid %0b taken %0b next_pc %h,",
                     $time, test_no, got.valid, got.taken, got.next_pc);
            $display("    expected valid %0b taken %0b next_pc %h",
                     want.valid, want.taken, want.next_pc);
            $display("TESTBENCH FAILED");
            $fatal(1, "prediction mismatch");
        end
    endtask

    task automatic check_kind(input int test_no, input bp_branch_pkg::branch_kind got,
                              input bp_branch_pkg::branch_kind want);
        if (got !== want) begin
            $display("Error at time %0t: test %0d kind %s, expected %s",
                     $time, test_no, got.name(), want.name());
            $display("TESTBENCH FAILED");
            $fatal(1, "branch kind mismatch");
        end
    endtask

    task automatic check_test(input int index);
        check_kind(index + 1, predict.kind, expected_q[index].kind);
        check_prediction(index + 1, predict, expected_q[index]);
    endtask

    //////////////////////////////
    // data file
    //////////////////////////////

    task automatic load_tests();
        int                           fd;
        int                           fields;
        string                        line;
        logic                         f_valid;
        logic [31:0]                  f_pc;
        logic [31:0]                  f_instr;
        logic                         u_valid;
        logic [1:0]                   u_kind;
        logic [31:0]                  u_pc;
        logic [31:0]                  u_target;
        logic                         u_taken;
        logic                         e_valid;
        logic [1:0]                   e_kind;
        logic                         e_taken;
        logic [31:0]                  e_next_pc;
        bp_branch_pkg::fetch_request  f;
        bp_branch_pkg::resolve_update u;
        bp_branch_pkg::prediction     e;
        fd = $fopen(test_file, "r");
        if (fd == 0) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "cannot open the test file %s", test_file);
        end else begin
            while ($fgets(line, fd) != 0) begin
                // blank lines and comments
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                     f_valid, f_pc, f_instr, u_valid, u_kind, u_pc,
                                     u_target, u_taken, e_valid, e_kind, e_taken, e_next_pc);
                    if (fields != field_count) begin
                        $display("TESTBENCH FAILED");
                        $fatal(1, "malformed line in the test file: %s", line);
                    end else begin
                        f.valid   = f_valid;
                        f.pc      = f_pc;
                        f.instr   = f_instr;
                        u.valid   = u_valid;
                        u.kind    = bp_branch_pkg::branch_kind'(u_kind);
                        u.pc      = u_pc;
                        u.target  = u_target;
                        u.taken   = u_taken;
                        e.valid   = e_valid;
                        e.kind    = bp_branch_pkg::branch_kind'(e_kind);
                        e.taken   = e_taken;
                        e.next_pc = e_next_pc;
                        fetch_q.push_back(f);
                        update_q.push_back(u);
                        expected_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        bp_branch_pkg::prediction    idle_prediction;
        bp_branch_pkg::fetch_request reset_fetch;
        tests_loaded <= 1'b0;
        reset        <= 1'b1;
        // valid fetch of a zero word held through reset
        reset_fetch       = '0;
        reset_fetch.valid = 1'b1;
        fetch        <= reset_fetch;
        update       <= '0;
        // zero word at pc 0 decodes to none with next pc 4
        idle_prediction.valid   = 1'b0;
        idle_prediction.kind    = bp_branch_pkg::kind_none;
        idle_prediction.taken   = 1'b0;
        idle_prediction.next_pc = 32'h0000_0004;
        load_tests();
        if (fetch_q.size() == 0) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "the test file holds no test lines");
        end else begin
            tests_loaded <= 1'b1;
            repeat (reset_cycles - 1) @(posedge clock);
            @(negedge clock);
            check_prediction(0, predict, idle_prediction);
            @(posedge clock);
            reset <= 1'b0;
            // each line is checked one cycle after it is driven
            for (int i = 0; i < fetch_q.size(); i++) begin
                @(posedge clock);
                fetch  <= fetch_q[i];
                update <= update_q[i];
                if (i > 0) begin
                    @(negedge clock);
                    check_test(i - 1);
                end
            end
            @(posedge clock);
            fetch  <= '0;
            update <= '0;
            @(negedge clock);
            check_test(fetch_q.size() - 1);
            // an idle fetch clears valid
            @(posedge clock);
            @(negedge clock);
            check_prediction(fetch_q.size() + 1, predict, idle_prediction);
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (tests_loaded);
        #((fetch_q.size() + reset_cycles + watchdog_slack) * clock_period);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout, the tests did not finish in the expected time");
    end

endmodule

/* verification/bp_tests.txt */
# fetch valid pc instr | update valid kind pc target taken | expected valid kind taken next_pc
# all hex; kind 0 none 1 branch 2 jal 3 jalr; expected values belong to the fetch on the same line
1 00001000 00000863 0 0 00000000 00000000 0 1 1 0 00001004
1 00001040 1000006f 0 0 00000000 00000000 0 1 2 1 00001140
1 00001080 00008067 0 0 00000000 00000000 0 1 3 0 00001084
1 00003000 00000013 1 1 00002010 00002800 1 1 0 0 00003004
1 00003004 00000013 1 1 00002010 00002800 1 1 0 0 00003008
1 00002010 00000863 0 0 00000000 00000000 0 1 1 1 00002800
1 00004024 00008067 1 3 00004024 00005550 1 1 3 0 00004028
1 00004024 00008067 0 0 00000000 00000000 0 1 3 1 00005550
1 00004424 00008067 0 0 00000000 00000000 0 1 3 0 00004428
1 00003008 00000013 1 2 00006030 00007000 1 1 0 0 0000300c
1 0000300c 00000013 1 2 00006430 00007100 1 1 0 0 00003010
1 00003010 00000013 1 2 00006830 00007200 1 1 0 0 00003014
1 00006030 1000006f 0 0 00000000 00000000 0 1 2 1 00006130
1 00006430 1000006f 0 0 00000000 00000000 0 1 2 1 00007100
1 00006830 1000006f 0 0 00000000 00000000 0 1 2 1 00007200
1 00003014 00000013 1 2 00006030 00007000 1 1 0 0 00003018
1 00006430 1000006f 0 0 00000000 00000000 0 1 2 1 00006530
1 00006030 1000006f 0 0 00000000 00000000 0 1 2 1 00007000
1 00008040 fe000ce3 1 1 00008040 00009000 1 1 1 0 00008044
1 00008040 fe000ce3 0 0 00000000 00000000 0 1 1 1 00009000
1 00000100 00000013 1 1 00002010 00002014 0 1 0 0 00000104
1 00002010 00000863 1 1 00002010 00002014 0 1 1 1 00002800
1 00002010 00000863 1 1 00002010 00002014 0 1 1 0 00002014
1 00000104 00000013 1 1 00002010 00002014 0 1 0 0 00000108
1 00002010 00000863 1 1 00002010 00002800 1 1 1 0 00002014
1 00002010 00000863 0 0 00000000 00000000 0 1 1 0 00002014
1 00008040 00000013 0 0 00000000 00000000 0 1 0 0 00008044

/* sim.f */
verilog/bp_config_pkg.sv
verilog/bp_branch_pkg.sv
verilog/branch_predecode.sv
verilog/btb.sv
verilog/direction_table.sv
verilog/prediction_select.sv
verilog/branch_predictor.sv
verification/branch_predictor_tb.sv

/* Makefile */
# Verilator build for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= branch_predictor_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?=

COMMON = --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON) $(VFLAGS)

# the simulator exit status carries pass or fail
sim:
	$(VERILATOR) --binary $(COMMON) -Mdir $(BUILD_DIR) $(VFLAGS)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
